//--- hdl/dpm_pkg.sv
// Shared widths, types and arbiter states for the dual-port memory built on one SRAM
// Every design file refers to these by scoped name
`default_nettype none

package dpm_pkg;

  // Address and data widths of the shared SRAM
  localparam int addr_w = 8;
  localparam int data_w = 8;

  // One word per address
  localparam int mem_depth = 256;

  // Client ports sharing the SRAM bus
  localparam int num_ports = 2;

  // Word address into the SRAM
  typedef logic [addr_w-1:0] addr_t;

  // One data word
  typedef logic [data_w-1:0] data_t;

  // Request as it travels from a client port to the SRAM
  // wr low means a read and wdata is then ignored
  typedef struct packed {
    logic  wr;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  // Read response back to a client
  // Kept as a struct so a tag can be added later
  typedef struct packed {
    data_t rdata;
  } rd_rsp_t;

  // Which port the arbiter served most recently
  typedef enum logic {
    last_p0 = 1'b0,
    last_p1 = 1'b1
  } arb_state_t;

endpackage

`default_nettype wire

//--- hdl/dpm_sram.sv
// Single-port synchronous SRAM with registered read data
// Driven only by the arbiter, one access per enabled cycle
`timescale 1ns/1ps
`default_nettype none

module dpm_sram (
  input  logic              m,
  input  logic              sram_en,
  input  dpm_pkg::mem_req_t sram_req,
  output dpm_pkg::data_t    sram_rdata
);

  // Contents undefined until written
  dpm_pkg::data_t mem [dpm_pkg::mem_depth];
  dpm_pkg::data_t rdata_q;

  always_ff @(posedge m) begin
    if (sram_en) begin
      if (sram_req.wr) begin
        mem[sram_req.addr] <= sram_req.wdata;
      end else begin
        // Read word appears on the cycle after the enable
        rdata_q <= mem[sram_req.addr];
      end
    end
  end

  assign sram_rdata = rdata_q;

endmodule

`default_nettype wire

//--- hdl/dpm_port.sv
// Client port front end holding one pending request and the last read response
// One instance per client port, it sits between the client and the arbiter
`timescale 1ns/1ps
`default_nettype none

module dpm_port (
  input  logic              m,
  input  logic              arst_n,
  // Request channel from the client
  input  logic              req_valid,
  output logic              req_ready,
  input  dpm_pkg::mem_req_t req,
  // Read response channel to the client
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output dpm_pkg::rd_rsp_t  rsp,
  // Towards the arbiter
  output logic              pend,
  output dpm_pkg::mem_req_t pend_req,
  input  logic              gnt,
  input  logic              rd_done,
  input  dpm_pkg::data_t    rd_data
);

  logic              pend_q;
  logic              rd_wait_q;
  logic              rsp_valid_q;
  dpm_pkg::mem_req_t pend_req_q;
  dpm_pkg::rd_rsp_t  rsp_q;
  logic              req_fire;
  logic              rsp_fire;

  // A read counts as unacknowledged from its grant until the client takes it
  assign req_ready = !pend_q && !rd_wait_q && !rsp_valid_q;
  assign req_fire  = req_valid && req_ready;
  assign rsp_fire  = rsp_valid_q && rsp_ready;

  always_ff @(posedge m or negedge arst_n) begin
    if (!arst_n) begin
      pend_q      <= 1'b0;
      rd_wait_q   <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_q       <= '0;
    end else begin
      if (req_fire) begin
        pend_q <= 1'b1;
      end else if (gnt) begin
        pend_q <= 1'b0;
      end

      // Read issued, SRAM data comes back with rd_done one cycle later
      if (gnt && !pend_req_q.wr) begin
        rd_wait_q <= 1'b1;
      end else if (rd_done) begin
        rd_wait_q <= 1'b0;
      end

      if (rd_done) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_valid_q <= 1'b0;
      end

      // Held after the handshake until the next read lands
      if (rd_done) begin
        rsp_q.rdata <= rd_data;
      end
    end
  end

  // Request payload
  always_ff @(posedge m) begin
    if (req_fire) begin
      pend_req_q <= req;
    end
  end

  assign pend      = pend_q;
  assign pend_req  = pend_req_q;
  assign rsp_valid = rsp_valid_q;
  assign rsp       = rsp_q;

  // Read data only comes back to a port with a read in flight
  a_rd_done_wait: assert property (@(posedge m) disable iff (!arst_n)
    rd_done |-> rd_wait_q)
    else $error("dpm_port: read data returned without a read in flight");

  // Response held until the client takes it
  a_rsp_stable: assert property (@(posedge m) disable iff (!arst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else $error("dpm_port: response changed before handshake");

endmodule

`default_nettype wire

//--- hdl/dpm_arbiter.sv
// Round-robin arbiter sharing the SRAM bus between the two client ports
// Grants one pending port per cycle and steers read data back to its owner
`timescale 1ns/1ps
`default_nettype none

module dpm_arbiter (
  input  logic              m,
  input  logic              arst_n,
  input  logic              pend0,
  input  dpm_pkg::mem_req_t pend_req0,
  input  logic              pend1,
  input  dpm_pkg::mem_req_t pend_req1,
  output logic              gnt0,
  output logic              gnt1,
  // Shared SRAM bus
  output logic              sram_en,
  output dpm_pkg::mem_req_t sram_req,
  input  dpm_pkg::data_t    sram_rdata,
  // Read return to the ports
  output logic              rd_done0,
  output logic              rd_done1,
  output dpm_pkg::data_t    rd_data
);

  dpm_pkg::arb_state_t          state_q;
  logic [dpm_pkg::num_ports-1:0] gnt_vec;
  logic [dpm_pkg::num_ports-1:0] rd_owner_q;

  // The port not served last wins a tie
  always_comb begin
    gnt_vec = '0;
    if (pend0 && pend1) begin
      if (state_q == dpm_pkg::last_p0) begin
        gnt_vec[1] = 1'b1;
      end else begin
        gnt_vec[0] = 1'b1;
      end
    end else if (pend0) begin
      gnt_vec[0] = 1'b1;
    end else if (pend1) begin
      gnt_vec[1] = 1'b1;
    end
  end

  assign gnt0     = gnt_vec[0];
  assign gnt1     = gnt_vec[1];
  assign sram_en  = |gnt_vec;
  assign sram_req = gnt_vec[1] ? pend_req1 : pend_req0;

  always_ff @(posedge m or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= dpm_pkg::last_p1;
      rd_owner_q <= '0;
    end else begin
      if (gnt_vec[0]) begin
        state_q <= dpm_pkg::last_p0;
      end else if (gnt_vec[1]) begin
        state_q <= dpm_pkg::last_p1;
      end
      // Owner of this cycle's read gets the data next cycle
      rd_owner_q <= gnt_vec & {dpm_pkg::num_ports{!sram_req.wr}};
    end
  end

  assign rd_done0 = rd_owner_q[0];
  assign rd_done1 = rd_owner_q[1];
  assign rd_data  = sram_rdata;

  a_gnt_onehot: assert property (@(posedge m) disable iff (!arst_n)
    !(gnt0 && gnt1))
    else $error("dpm_arbiter: both ports granted");

  a_gnt_pend: assert property (@(posedge m) disable iff (!arst_n)
    (!gnt0 || pend0) && (!gnt1 || pend1))
    else $error("dpm_arbiter: grant without pending request");

  a_en_gnt: assert property (@(posedge m) disable iff (!arst_n)
    sram_en == (gnt0 || gnt1))
    else $error("dpm_arbiter: SRAM enable out of step with grants");

  // A port that loses a tie is served in the very next cycle
  a_rr_wait0: assert property (@(posedge m) disable iff (!arst_n)
    (pend0 && !gnt0) |=> gnt0)
    else $error("dpm_arbiter: port 0 waited more than one cycle");

  a_rr_wait1: assert property (@(posedge m) disable iff (!arst_n)
    (pend1 && !gnt1) |=> gnt1)
    else $error("dpm_arbiter: port 1 waited more than one cycle");

endmodule

`default_nettype wire

//--- hdl/dual_port_memory.sv
// Dual-port memory top built from one single-port SRAM
// Two independent valid/ready client ports share the SRAM through a round-robin arbiter
`timescale 1ns/1ps
`default_nettype none

module dual_port_memory (
  input  logic              m,
  input  logic              arst_n,
  // Port 0
  input  logic              p0_req_valid,
  output logic              p0_req_ready,
  input  dpm_pkg::mem_req_t p0_req,
  output logic              p0_rsp_valid,
  input  logic              p0_rsp_ready,
  output dpm_pkg::rd_rsp_t  p0_rsp,
  // Port 1
  input  logic              p1_req_valid,
  output logic              p1_req_ready,
  input  dpm_pkg::mem_req_t p1_req,
  output logic              p1_rsp_valid,
  input  logic              p1_rsp_ready,
  output dpm_pkg::rd_rsp_t  p1_rsp
);

  logic              pend0;
  logic              pend1;
  dpm_pkg::mem_req_t pend_req0;
  dpm_pkg::mem_req_t pend_req1;
  logic              gnt0;
  logic              gnt1;
  logic              rd_done0;
  logic              rd_done1;
  dpm_pkg::data_t    rd_data;
  logic              sram_en;
  dpm_pkg::mem_req_t sram_req;
  dpm_pkg::data_t    sram_rdata;

  dpm_port u_port0 (
    .m         (m),
    .arst_n    (arst_n),
    .req_valid (p0_req_valid),
    .req_ready (p0_req_ready),
    .req       (p0_req),
    .rsp_valid (p0_rsp_valid),
    .rsp_ready (p0_rsp_ready),
    .rsp       (p0_rsp),
    .pend      (pend0),
    .pend_req  (pend_req0),
    .gnt       (gnt0),
    .rd_done   (rd_done0),
    .rd_data   (rd_data)
  );

  dpm_port u_port1 (
    .m         (m),
    .arst_n    (arst_n),
    .req_valid (p1_req_valid),
    .req_ready (p1_req_ready),
    .req       (p1_req),
    .rsp_valid (p1_rsp_valid),
    .rsp_ready (p1_rsp_ready),
    .rsp       (p1_rsp),
    .pend      (pend1),
    .pend_req  (pend_req1),
    .gnt       (gnt1),
    .rd_done   (rd_done1),
    .rd_data   (rd_data)
  );

  dpm_arbiter u_arb (
    .m          (m),
    .arst_n     (arst_n),
    .pend0      (pend0),
    .pend_req0  (pend_req0),
    .pend1      (pend1),
    .pend_req1  (pend_req1),
    .gnt0       (gnt0),
    .gnt1       (gnt1),
    .sram_en    (sram_en),
    .sram_req   (sram_req),
    .sram_rdata (sram_rdata),
    .rd_done0   (rd_done0),
    .rd_done1   (rd_done1),
    .rd_data    (rd_data)
  );

  dpm_sram u_sram (
    .m          (m),
    .sram_en    (sram_en),
    .sram_req   (sram_req),
    .sram_rdata (sram_rdata)
  );

endmodule

`default_nettype wire

//--- test/tb_dual_port_memory.sv
// Vector-driven testbench for the dual-port memory
// Walks test/dpm_vectors.txt phase by phase with one driver per client port
`timescale 1ns/1ps
`default_nettype none

module tb_dual_port_memory;

  localparam time clk_period  = 40;
  localparam time half_period = 20;
  localparam int  vec_fields  = 6;
  localparam int  max_vec     = 128;
  localparam int  num_phases  = 9;
  // Phase and port that see random rsp_ready
  localparam int  bp_phase    = 8;
  localparam int  bp_port     = 0;
  localparam time margin      = 4000;
  localparam logic [31:0] seed = 32'hb66c;

  logic              m;
  logic              arst_n;
  logic              req_valid [2];
  logic              req_ready [2];
  dpm_pkg::mem_req_t req [2];
  logic              rsp_valid [2];
  logic              rsp_ready [2];
  dpm_pkg::rd_rsp_t  rsp [2];

  logic [7:0]     vec_mem [max_vec * vec_fields];
  int             num_vec;
  int             errors;
  dpm_pkg::data_t ref_mem [dpm_pkg::mem_depth];
  logic           ref_written [dpm_pkg::mem_depth];
  dpm_pkg::data_t last_rd [2];
  logic           has_rd [2];
  logic           port_busy [2];

  dual_port_memory u_dut (
    .m            (m),
    .arst_n       (arst_n),
    .p0_req_valid (req_valid[0]),
    .p0_req_ready (req_ready[0]),
    .p0_req       (req[0]),
    .p0_rsp_valid (rsp_valid[0]),
    .p0_rsp_ready (rsp_ready[0]),
    .p0_rsp       (rsp[0]),
    .p1_req_valid (req_valid[1]),
    .p1_req_ready (req_ready[1]),
    .p1_req       (req[1]),
    .p1_rsp_valid (rsp_valid[1]),
    .p1_rsp_ready (rsp_ready[1]),
    .p1_rsp       (rsp[1])
  );

  initial begin
    m = 1'b0;
    forever #(half_period) m = ~m;
  end

  function automatic logic [7:0] field(input int idx, input int col);
    return vec_mem[idx * vec_fields + col];
  endfunction

  function automatic int count_vectors();
    int n;
    n = 0;
    // Unused entries keep the ff fill
    while (n < max_vec && vec_mem[n * vec_fields] != 8'hff) begin
      n++;
    end
    return n;
  endfunction

  function automatic logic has_vectors(input int port, input int phase);
    logic found;
    found = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      if (int'(field(i, 0)) == phase && int'(field(i, 1)) == port) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  function automatic string phase_label(input int phase);
    case (phase)
      1:       return "p0_write";
      2:       return "p0_read_back";
      3:       return "p1_write_shared";
      4:       return "p0_read_cross";
      5:       return "p0_write_shared";
      6:       return "p1_read_cross";
      7:       return "concurrent";
      8:       return "back_pressure";
      9:       return "held_read_data";
      default: return "unknown";
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [7:0] expd,
                                 input logic [7:0] act);
    $display("mismatch %s: expected %h, actual %h", name, expd, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t ns: %s", $time, what);
    errors++;
  endtask

  task automatic watchdog(input time limit);
    #(limit);
    $display("watchdog expired at %0t ns, a handshake never completed", $time);
    $display("%0d errors before the timeout", errors);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic check_reset_state();
    @(negedge m);
    for (int p = 0; p < 2; p++) begin
      assert (req_ready[p])
        else report_failure($sformatf("port %0d req_ready is low after reset", p));
      assert (!rsp_valid[p])
        else report_failure($sformatf("port %0d rsp_valid is high after reset", p));
    end
  endtask

  task automatic run_txn(input int port, input int phase, input int idx);
    dpm_pkg::mem_req_t r;
    dpm_pkg::data_t    exp_data;
    dpm_pkg::data_t    held;
    string             name;
    time               t_acc;
    time               t_rise;
    int                lat;
    logic              bp;
    logic              seen;
    logic              done;
    r.wr     = (field(idx, 2) != 8'h00);
    r.addr   = field(idx, 3);
    r.wdata  = field(idx, 4);
    exp_data = field(idx, 5);
    name     = $sformatf("%s[%0d] p%0d", phase_label(phase), idx, port);
    bp       = (phase == bp_phase) && (port == bp_port);
    seen     = 1'b0;
    done     = 1'b0;
    held     = '0;

    @(posedge m);
    req_valid[port] <= 1'b1;
    req[port]       <= r;
    do begin
      @(negedge m);
    end while (!req_ready[port]);
    @(posedge m);
    t_acc = $time;
    req_valid[port] <= 1'b0;

    if (r.wr) begin
      ref_mem[r.addr]     = r.wdata;
      ref_written[r.addr] = 1'b1;
      // Port frees up once the write has reached the SRAM
      do begin
        @(negedge m);
      end while (!req_ready[port]);
      if (has_rd[port]) begin
        assert (rsp[port].rdata == last_rd[port])
          else report_mismatch({name, " held rsp"}, last_rd[port], rsp[port].rdata);
      end
    end else begin
      assert (ref_written[r.addr])
        else report_failure({name, " reads an address that was never written"});
      assert (ref_mem[r.addr] == exp_data)
        else report_mismatch({name, " vector vs model"}, ref_mem[r.addr], exp_data);
      while (!done) begin
        @(posedge m);
        if (bp) begin
          rsp_ready[port] <= 1'($urandom);
        end
        @(negedge m);
        if (rsp_valid[port]) begin
          if (!seen) begin
            seen   = 1'b1;
            held   = rsp[port].rdata;
            t_rise = $time - half_period;
            lat    = int'((t_rise - t_acc) / clk_period);
            assert (held == exp_data)
              else report_mismatch(name, exp_data, held);
            // One extra cycle allowed only when the other port competes
            if (port_busy[1 - port]) begin
              assert (lat >= 2 && lat <= 3)
                else report_failure($sformatf("%s read latency %0d cycles", name, lat));
            end else begin
              assert (lat == 2)
                else report_failure($sformatf("%s read latency %0d cycles", name, lat));
            end
          end else begin
            assert (rsp[port].rdata == held)
              else report_mismatch({name, " stable rsp"}, held, rsp[port].rdata);
          end
          assert (!req_ready[port])
            else report_failure({name, " req_ready high while a response waits"});
          done = rsp_ready[port];
        end
      end
      // Handshake edge
      @(posedge m);
      last_rd[port] = held;
      has_rd[port]  = 1'b1;
    end
  endtask

  task automatic run_port(input int port, input int phase);
    for (int i = 0; i < num_vec; i++) begin
      if (int'(field(i, 0)) == phase && int'(field(i, 1)) == port) begin
        run_txn(port, phase, i);
      end
    end
  endtask

  initial begin
    void'($urandom(seed));
    errors = 0;
    arst_n = 1'b0;
    for (int p = 0; p < 2; p++) begin
      req_valid[p] = 1'b0;
      req[p]       = '0;
      rsp_ready[p] = 1'b1;
      last_rd[p]   = '0;
      has_rd[p]    = 1'b0;
      port_busy[p] = 1'b0;
    end
    for (int a = 0; a < dpm_pkg::mem_depth; a++) begin
      ref_mem[a]     = '0;
      ref_written[a] = 1'b0;
    end
    for (int i = 0; i < max_vec * vec_fields; i++) begin
      vec_mem[i] = 8'hff;
    end
    $readmemh("test/dpm_vectors.txt", vec_mem);
    num_vec = count_vectors();
    fork
      watchdog(time'(num_vec) * 10 * clk_period + margin);
    join_none

    repeat (2) @(posedge m);
    arst_n <= 1'b1;
    check_reset_state();

    // Phases run in order so cross-port reads see completed writes
    for (int ph = 1; ph <= num_phases; ph++) begin
      port_busy[0] = has_vectors(0, ph);
      port_busy[1] = has_vectors(1, ph);
      fork
        run_port(0, ph);
        run_port(1, ph);
      join
    end

    $display("%0d vectors run, %0d errors", num_vec, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/dpm_vectors.txt
// Columns are phase, port, op (1 write, 0 read), address, write data and expected read data
// All values in hex and expected data is 00 for writes

// Phase 1 port 0 writes the low words
1 0 1 00 3c 00
1 0 1 01 a5 00
1 0 1 02 5a 00
1 0 1 03 0f 00
1 0 1 04 f0 00
1 0 1 05 81 00
1 0 1 06 7e 00
1 0 1 07 19 00

// Phase 2 port 0 reads them back alone
2 0 0 00 00 3c
2 0 0 01 00 a5
2 0 0 02 00 5a
2 0 0 03 00 0f
2 0 0 04 00 f0
2 0 0 05 00 81
2 0 0 06 00 7e
2 0 0 07 00 19

// Phase 3 port 1 writes shared words
3 1 1 40 c3 00
3 1 1 41 12 00
3 1 1 42 34 00
3 1 1 43 ee 00

// Phase 4 port 0 reads what port 1 wrote
4 0 0 40 00 c3
4 0 0 41 00 12
4 0 0 42 00 34
4 0 0 43 00 ee

// Phase 5 port 0 writes shared words
5 0 1 50 9a 00
5 0 1 51 6b 00
5 0 1 52 01 00
5 0 1 53 fe 00

// Phase 6 port 1 reads what port 0 wrote
6 1 0 50 00 9a
6 1 0 51 00 6b
6 1 0 52 00 01
6 1 0 53 00 fe

// Phase 7 both ports stream into disjoint ranges
7 0 1 10 11 00
7 0 1 11 22 00
7 0 0 10 00 11
7 0 1 12 33 00
7 0 0 11 00 22
7 0 1 13 44 00
7 0 0 12 00 33
7 0 1 14 55 00
7 0 0 13 00 44
7 0 1 15 66 00
7 0 1 16 77 00
7 0 1 17 88 00
7 0 0 14 00 55
7 0 0 15 00 66
7 0 0 16 00 77
7 0 0 17 00 88
7 1 1 80 a1 00
7 1 1 81 b2 00
7 1 1 82 c3 00
7 1 1 83 d4 00
7 1 0 80 00 a1
7 1 0 81 00 b2
7 1 1 84 e5 00
7 1 1 85 f6 00
7 1 0 82 00 c3
7 1 0 83 00 d4
7 1 1 86 07 00
7 1 1 87 18 00
7 1 0 84 00 e5
7 1 0 85 00 f6
7 1 0 86 00 07
7 1 0 87 00 18

// Phase 8 port 0 reads under random rsp_ready while port 1 keeps going
8 0 0 10 00 11
8 0 0 11 00 22
8 0 0 12 00 33
8 0 0 13 00 44
8 0 0 14 00 55
8 0 0 15 00 66
8 0 0 16 00 77
8 0 0 17 00 88
8 1 1 90 2a 00
8 1 1 91 3b 00
8 1 0 90 00 2a
8 1 1 92 4c 00
8 1 0 91 00 3b
8 1 1 93 5d 00
8 1 0 92 00 4c
8 1 0 93 00 5d

// Phase 9 a read followed by a write, rsp must still show the read
9 1 0 80 00 a1
9 1 1 a0 99 00
9 1 0 81 00 b2
9 1 1 a1 98 00
9 0 0 00 00 3c
9 0 1 08 97 00

//--- vlog.f
hdl/dpm_pkg.sv
hdl/dpm_sram.sv
hdl/dpm_port.sv
hdl/dpm_arbiter.sv
hdl/dual_port_memory.sv
test/tb_dual_port_memory.sv

//--- run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and grep the log for the fail message
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f vlog.f --top-module tb_dual_port_memory -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  && ! grep -q "TEST FAILED" sim.log \
  && echo "simulation passed, log in sim.log" \
  || { echo "simulation failed, see sim.log"; exit 1; }
